/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module tbAccl -Mdir obj_dir
	./obj_dir/VtbAccl | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* acclPkg.sv */
/*
 * Convolution accelerator definitions
 * Filter geometry, queue sizing, APB register map and vector types
 */
package acclPkg;

	// Filter geometry, one tap per coefficient
	localparam int FilterRows = 3;
	localparam int FilterLayers = 3;
	localparam int NumTaps = FilterRows * FilterLayers;
	localparam int FillBits = $clog2(NumTaps + 1);

	// Result queue sizing
	localparam int FifoDepth = 8;
	localparam int CountBits = 4;
	localparam int PtrBits = $clog2(FifoDepth);

	// Bus and datapath widths
	localparam int AddrBits = 12;
	localparam int WordBits = 32;
	localparam int SampleBits = 16;

	typedef logic [AddrBits-1:0] addrT;
	typedef logic [WordBits-1:0] wordT;
	typedef logic signed [SampleBits-1:0] sampleT;
	typedef logic signed [SampleBits-1:0] coefT;
	typedef logic signed [WordBits-1:0] productT;

	// Register map, byte addresses
	localparam addrT AddrControl = 12'h000;
	localparam addrT AddrStatus = 12'h004;
	localparam addrT AddrCoeffBase = 12'h100;
	localparam addrT AddrData = 12'h200;
	localparam addrT AddrResult = 12'h300;

	// Status register fields
	localparam int StatusFullBit = 8;

	// Control register fields
	localparam int ControlClearBit = 0;

endpackage

/* accl_tests.txt */
# op addr data expected name; op W write, R read, E read expecting error, P poll count
# all numbers hex; for P the data column is the status count to wait for
R 004 0 0 statusAfterReset
W 100 7fff 0 wrCoef0
W 104 7fff 0 wrCoef1
W 108 7fff 0 wrCoef2
W 10c fffd 0 wrCoef3
W 110 12340002 0 wrCoef4
W 120 ffff 0 wrCoef8
R 100 0 7fff rdCoef0
R 10c 0 fffffffd rdCoef3
R 110 0 2 rdCoef4
R 114 0 0 rdCoef5
R 120 0 ffffffff rdCoef8
R 050 0 0 rdUnmapped
W 200 1 0 sample1
W 200 2 0 sample2
W 200 3 0 sample3
W 200 4 0 sample4
W 200 5 0 sample5
W 200 6 0 sample6
W 200 7 0 sample7
W 200 8 0 sample8
R 004 0 0 statusAfter8
W 200 9 0 sample9
P 004 1 0 pollFirst
R 300 0 bffdf resultWindow9
W 200 fffb 0 sample10
W 200 7fff 0 sample11
W 200 7fff 0 sample12
W 200 7fff 0 sample13
W 200 1 0 sample14
W 200 2 0 sample15
W 200 3 0 sample16
W 200 4 0 sample17
P 004 8 0 pollFull
R 004 0 108 statusFull
R 300 0 5ffe9 resultWindow10
R 300 0 4000fff0 resultWindow11
R 300 0 7ffb7ff8 resultWindow12
R 300 0 bffd001f resultWindow13
R 300 0 7ffcfff4 resultWindow14
R 300 0 3ffffff8 resultWindow15
R 300 0 27ff3 resultWindow16
R 300 0 57fe9 resultWindow17
E 300 0 0 readEmpty
W 200 5 0 sample18
P 004 1 0 pollBeforeClear
W 000 1 0 controlClear
R 004 0 0 statusAfterClear
W 200 1 0 clrSample1
W 200 2 0 clrSample2
W 200 3 0 clrSample3
W 200 4 0 clrSample4
W 200 5 0 clrSample5
W 200 6 0 clrSample6
W 200 7 0 clrSample7
W 200 8 0 clrSample8
R 004 0 0 statusClear8
W 200 9 0 clrSample9
P 004 1 0 pollAfterClear
R 300 0 bffdf resultAfterClear

/* apbRegBank.sv */
/*
 * APB register bank
 * Address decode, coefficient storage, control and status registers,
 * sample push with wait states while the result queue has no room
 */
`timescale 1ns/1ps

module apbRegBank (
	input  logic clk,
	input  logic rst,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  acclPkg::addrT paddr,
	input  acclPkg::wordT pwdata,
	input  logic space,
	input  logic full,
	input  logic empty,
	input  logic [acclPkg::CountBits-1:0] count,
	input  acclPkg::wordT head,
	output acclPkg::wordT prdata,
	output logic pready,
	output logic pslverr,
	output logic sampleValid,
	output acclPkg::sampleT sample,
	output acclPkg::coefT coef0,
	output acclPkg::coefT coef1,
	output acclPkg::coefT coef2,
	output acclPkg::coefT coef3,
	output acclPkg::coefT coef4,
	output acclPkg::coefT coef5,
	output acclPkg::coefT coef6,
	output acclPkg::coefT coef7,
	output acclPkg::coefT coef8,
	output logic pop,
	output logic clear
);

	acclPkg::coefT coefReg [acclPkg::NumTaps];
	acclPkg::addrT coefOffset;
	logic [3:0] coefIdx;
	logic coefHit;
	logic isControl;
	logic isStatus;
	logic isData;
	logic isResult;
	logic complete;
	logic wrDone;
	logic rdDone;

	// Address decode
	assign isControl = (paddr == acclPkg::AddrControl);
	assign isStatus = (paddr == acclPkg::AddrStatus);
	assign isData = (paddr == acclPkg::AddrData);
	assign isResult = (paddr == acclPkg::AddrResult);

	// Addresses below the base wrap to a large offset and miss
	assign coefOffset = paddr - acclPkg::AddrCoeffBase;
	assign coefIdx = coefOffset[5:2];
	assign coefHit = (coefOffset < acclPkg::addrT'(4 * acclPkg::NumTaps)) &&
		(coefOffset[1:0] == 2'b00);

	// Data writes wait until the queue can take the result they may produce
	assign pready = !(psel && pwrite && isData && !space);

	assign complete = psel && penable && pready;
	assign wrDone = complete && pwrite;
	assign rdDone = complete && !pwrite;

	// Strobes for the datapath, all in the completing cycle
	assign sampleValid = wrDone && isData;
	assign sample = pwdata[acclPkg::SampleBits-1:0];
	assign clear = wrDone && isControl && pwdata[acclPkg::ControlClearBit];
	assign pop = rdDone && isResult && !empty;

	// Empty result read is the only error response
	assign pslverr = rdDone && isResult && empty;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < acclPkg::NumTaps; k++) begin
				coefReg[k] <= '0;
			end
		end else if (wrDone && coefHit) begin
			coefReg[coefIdx] <= pwdata[acclPkg::SampleBits-1:0];
		end
	end

	// Read data mux, unmapped and control addresses read zero
	always_comb begin
		prdata = '0;
		if (isStatus) begin
			prdata[acclPkg::CountBits-1:0] = count;
			prdata[acclPkg::StatusFullBit] = full;
		end else if (coefHit) begin
			prdata = {{(acclPkg::WordBits - acclPkg::SampleBits){coefReg[coefIdx][15]}},
				coefReg[coefIdx]};
		end else if (isResult && !empty) begin
			prdata = head;
		end
	end

	assign coef0 = coefReg[0];
	assign coef1 = coefReg[1];
	assign coef2 = coefReg[2];
	assign coef3 = coefReg[3];
	assign coef4 = coefReg[4];
	assign coef5 = coefReg[5];
	assign coef6 = coefReg[6];
	assign coef7 = coefReg[7];
	assign coef8 = coefReg[8];

endmodule

/* convAcclTop.sv */
/*
 * Convolution accelerator top level
 * APB register bank feeding the sample window, dot-product pipeline
 * and result FIFO
 */
`timescale 1ns/1ps

module convAcclTop (
	input  logic clk,
	input  logic rst,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  acclPkg::addrT paddr,
	input  acclPkg::wordT pwdata,
	output acclPkg::wordT prdata,
	output logic pready,
	output logic pslverr
);

	logic sampleValid;
	acclPkg::sampleT sample;
	acclPkg::coefT coef0, coef1, coef2, coef3, coef4, coef5, coef6, coef7, coef8;
	acclPkg::sampleT tap0, tap1, tap2, tap3, tap4, tap5, tap6, tap7, tap8;
	logic windowValid;
	logic resultValid;
	acclPkg::wordT result;
	acclPkg::wordT head;
	logic [acclPkg::CountBits-1:0] count;
	logic full;
	logic empty;
	logic space;
	logic pop;
	logic clear;

	apbRegBank uRegBank (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.space(space), .full(full), .empty(empty), .count(count), .head(head),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.sampleValid(sampleValid), .sample(sample),
		.coef0(coef0), .coef1(coef1), .coef2(coef2), .coef3(coef3), .coef4(coef4),
		.coef5(coef5), .coef6(coef6), .coef7(coef7), .coef8(coef8),
		.pop(pop), .clear(clear)
	);

	sampleWindow uWindow (
		.clk(clk), .rst(rst), .clear(clear),
		.sampleValid(sampleValid), .sample(sample),
		.windowValid(windowValid),
		.tap0(tap0), .tap1(tap1), .tap2(tap2), .tap3(tap3), .tap4(tap4),
		.tap5(tap5), .tap6(tap6), .tap7(tap7), .tap8(tap8)
	);

	dotProductPipe uDotPipe (
		.clk(clk), .rst(rst), .clear(clear),
		.windowValid(windowValid),
		.tap0(tap0), .tap1(tap1), .tap2(tap2), .tap3(tap3), .tap4(tap4),
		.tap5(tap5), .tap6(tap6), .tap7(tap7), .tap8(tap8),
		.coef0(coef0), .coef1(coef1), .coef2(coef2), .coef3(coef3), .coef4(coef4),
		.coef5(coef5), .coef6(coef6), .coef7(coef7), .coef8(coef8),
		.resultValid(resultValid), .result(result)
	);

	// windowValid doubles as the reservation for the result it will produce
	resultFifo uFifo (
		.clk(clk), .rst(rst), .clear(clear),
		.reserve(windowValid), .push(resultValid), .result(result), .pop(pop),
		.head(head), .count(count), .full(full), .empty(empty), .space(space)
	);

endmodule

/* dotProductPipe.sv */
/*
 * Dot-product pipeline
 * Stage one forms nine signed products, stage two sums them to 32 bits
 */
`timescale 1ns/1ps

module dotProductPipe (
	input  logic clk,
	input  logic rst,
	input  logic clear,
	input  logic windowValid,
	input  acclPkg::sampleT tap0,
	input  acclPkg::sampleT tap1,
	input  acclPkg::sampleT tap2,
	input  acclPkg::sampleT tap3,
	input  acclPkg::sampleT tap4,
	input  acclPkg::sampleT tap5,
	input  acclPkg::sampleT tap6,
	input  acclPkg::sampleT tap7,
	input  acclPkg::sampleT tap8,
	input  acclPkg::coefT coef0,
	input  acclPkg::coefT coef1,
	input  acclPkg::coefT coef2,
	input  acclPkg::coefT coef3,
	input  acclPkg::coefT coef4,
	input  acclPkg::coefT coef5,
	input  acclPkg::coefT coef6,
	input  acclPkg::coefT coef7,
	input  acclPkg::coefT coef8,
	output logic resultValid,
	output acclPkg::wordT result
);

	acclPkg::sampleT taps [acclPkg::NumTaps];
	acclPkg::coefT coefs [acclPkg::NumTaps];
	acclPkg::productT prod [acclPkg::NumTaps];
	acclPkg::productT prodSum;
	logic stage1Valid;

	assign taps = '{tap0, tap1, tap2, tap3, tap4, tap5, tap6, tap7, tap8};
	assign coefs = '{coef0, coef1, coef2, coef3, coef4, coef5, coef6, coef7, coef8};

	// Valid bits travel alongside the two data stages
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			stage1Valid <= 1'b0;
			resultValid <= 1'b0;
		end else begin
			stage1Valid <= windowValid;
			resultValid <= stage1Valid;
		end
	end

	// Stage one, full-precision signed products
	always_ff @(posedge clk) begin
		for (int k = 0; k < acclPkg::NumTaps; k++) begin
			prod[k] <= acclPkg::productT'(taps[k]) * acclPkg::productT'(coefs[k]);
		end
	end

	// Adder tree, overflow wraps modulo 2^32
	always_comb begin
		prodSum = '0;
		for (int k = 0; k < acclPkg::NumTaps; k++) begin
			prodSum = prodSum + prod[k];
		end
	end

	// Stage two
	always_ff @(posedge clk) begin
		result <= acclPkg::wordT'(prodSum);
	end

endmodule

/* flist.f */
acclPkg.sv
apbRegBank.sv
sampleWindow.sv
dotProductPipe.sv
resultFifo.sv
convAcclTop.sv
tbAccl_asserts.sv
tbAccl.sv

/* resultFifo.sv */
/*
 * Result FIFO
 * Circular queue of results with a reservation count for windows
 * still in the pipeline, so space covers results not yet pushed
 */
`timescale 1ns/1ps

module resultFifo (
	input  logic clk,
	input  logic rst,
	input  logic clear,
	input  logic reserve,
	input  logic push,
	input  acclPkg::wordT result,
	input  logic pop,
	output acclPkg::wordT head,
	output logic [acclPkg::CountBits-1:0] count,
	output logic full,
	output logic empty,
	output logic space
);

	acclPkg::wordT mem [acclPkg::FifoDepth];
	logic [acclPkg::PtrBits-1:0] wrPtr;
	logic [acclPkg::PtrBits-1:0] rdPtr;
	logic [acclPkg::CountBits-1:0] resv;
	logic [acclPkg::CountBits:0] committed;
	logic doPush;
	logic doPop;

	assign full = (count == (acclPkg::CountBits)'(acclPkg::FifoDepth));
	assign empty = (count == '0);
	assign doPush = push && !full;
	assign doPop = pop && !empty;

	// Entries stored plus entries promised to the pipeline
	assign committed = {1'b0, count} + {1'b0, resv};
	assign space = (committed < (acclPkg::CountBits + 1)'(acclPkg::FifoDepth));

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			resv <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
			// Taken when a window leaves the shift chain, returned on push
			case ({reserve, push})
				2'b10: resv <= resv + 1'b1;
				2'b01: resv <= resv - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (doPush) begin
			mem[wrPtr] <= result;
		end
	end

	assign head = mem[rdPtr];

endmodule

/* sampleWindow.sv */
/*
 * Sample window
 * Nine-deep shift chain over the sample stream, flags each full window
 */
`timescale 1ns/1ps

module sampleWindow (
	input  logic clk,
	input  logic rst,
	input  logic clear,
	input  logic sampleValid,
	input  acclPkg::sampleT sample,
	output logic windowValid,
	output acclPkg::sampleT tap0,
	output acclPkg::sampleT tap1,
	output acclPkg::sampleT tap2,
	output acclPkg::sampleT tap3,
	output acclPkg::sampleT tap4,
	output acclPkg::sampleT tap5,
	output acclPkg::sampleT tap6,
	output acclPkg::sampleT tap7,
	output acclPkg::sampleT tap8
);

	acclPkg::sampleT win [acclPkg::NumTaps];
	logic [acclPkg::FillBits-1:0] fill;
	logic fillDone;
	logic lastMissing;

	assign fillDone = (fill == (acclPkg::FillBits)'(acclPkg::NumTaps));
	assign lastMissing = (fill == (acclPkg::FillBits)'(acclPkg::NumTaps - 1));

	// Fill count saturates once the chain holds a whole window
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			fill <= '0;
			windowValid <= 1'b0;
		end else begin
			windowValid <= sampleValid && (fillDone || lastMissing);
			if (sampleValid && !fillDone) begin
				fill <= fill + 1'b1;
			end
		end
	end

	// Newest sample enters at tap 0
	always_ff @(posedge clk) begin
		if (sampleValid) begin
			win[0] <= sample;
			for (int k = 1; k < acclPkg::NumTaps; k++) begin
				win[k] <= win[k-1];
			end
		end
	end

	assign tap0 = win[0];
	assign tap1 = win[1];
	assign tap2 = win[2];
	assign tap3 = win[3];
	assign tap4 = win[4];
	assign tap5 = win[5];
	assign tap6 = win[6];
	assign tap7 = win[7];
	assign tap8 = win[8];

endmodule

/* tbAccl.sv */
/*
 * Testbench for the convolution accelerator
 * Runs the APB operations listed in the tests file and checks every read
 */
`timescale 1ns/1ps

module tbAccl;

	logic clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	acclPkg::addrT paddr;
	acclPkg::wordT pwdata;
	acclPkg::wordT prdata;
	logic pready;
	logic pslverr;

	string opQ[$];
	string nameQ[$];
	acclPkg::wordT addrQ[$];
	acclPkg::wordT dataQ[$];
	acclPkg::wordT expQ[$];
	int testCount;
	bit opened;
	bit loaded;
	int mismatchCount;
	int otherCount;

	convAcclTop u_dut (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	always #4 clk = ~clk;

	// One APB transfer with outputs sampled mid-cycle once pready is high
	task automatic apbTransfer(input bit wr, input acclPkg::wordT addr,
		input acclPkg::wordT data, output acclPkg::wordT rd, output bit err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= acclPkg::addrT'(addr);
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		do begin
			@(negedge clk);
		end while (!pready);
		rd = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic loadTests(output bit ok);
		int fd;
		int n;
		string line;
		string op;
		string nm;
		acclPkg::wordT a;
		acclPkg::wordT d;
		acclPkg::wordT e;
		fd = $fopen("accl_tests.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 1 && line[0] != "#") begin
					if ($sscanf(line, "%s %h %h %h %s", op, a, d, e, nm) == 5) begin
						opQ.push_back(op);
						addrQ.push_back(a);
						dataQ.push_back(d);
						expQ.push_back(e);
						nameQ.push_back(nm);
					end
				end
			end
			$fclose(fd);
			testCount = opQ.size();
		end
	endtask

	// Status is read until its count field reaches the target
	task automatic pollCount(input acclPkg::wordT addr, input acclPkg::wordT target,
		input string nm);
		acclPkg::wordT rd;
		bit err;
		bit reached;
		reached = 1'b0;
		for (int k = 0; k < 40 && !reached; k++) begin
			apbTransfer(1'b0, addr, '0, rd, err);
			reached = (rd[acclPkg::CountBits-1:0] == target[acclPkg::CountBits-1:0]);
		end
		assert (reached) else begin
			$display("%s: status count never reached %0d", nm, target);
			otherCount++;
		end
	endtask

	task automatic runTest(input int i);
		acclPkg::wordT rd;
		bit err;
		case (opQ[i])
			"W": apbTransfer(1'b1, addrQ[i], dataQ[i], rd, err);
			"R": begin
				apbTransfer(1'b0, addrQ[i], '0, rd, err);
				assert (!err && rd === expQ[i]) else begin
					$display("mismatch %s: expected %h, actual %h, pslverr %b",
						nameQ[i], expQ[i], rd, err);
					mismatchCount++;
				end
			end
			"E": begin
				apbTransfer(1'b0, addrQ[i], '0, rd, err);
				assert (err && rd === expQ[i]) else begin
					$display("mismatch %s: expected %h with pslverr, actual %h, pslverr %b",
						nameQ[i], expQ[i], rd, err);
					mismatchCount++;
				end
			end
			"P": pollCount(addrQ[i], dataQ[i], nameQ[i]);
			default: begin
				$display("unknown operation %s in test %s", opQ[i], nameQ[i]);
				otherCount++;
			end
		endcase
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		mismatchCount = 0;
		otherCount = 0;
		loadTests(opened);
		if (!opened) begin
			$display("cannot open the tests file accl_tests.txt");
			$display("Simulation failed");
			$finish;
		end else begin
			loaded = 1'b1;
			repeat (5) @(posedge clk);
			rst <= 1'b0;
			for (int i = 0; i < testCount; i++) begin
				runTest(i);
			end
			repeat (2) @(posedge clk);
			$display("%0d tests, %0d mismatches, %0d other errors",
				testCount, mismatchCount, otherCount);
			if (mismatchCount == 0 && otherCount == 0) begin
				$display("Simulation completed successfully");
			end else begin
				$display("Simulation failed");
			end
			$finish;
		end
	end

	// Watchdog allows 50 cycles per test line plus reset
	initial begin
		wait (loaded);
		repeat ((testCount + 5) * 50) @(posedge clk);
		$display("timeout, the tests did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

/* tbAccl_asserts.sv */
/*
 * APB protocol and queue checks, bound into the accelerator top level
 */
`timescale 1ns/1ps

module tbAccl_asserts (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic pready,
	input logic pslverr,
	input acclPkg::wordT prdata,
	input logic resultValid,
	input logic [acclPkg::CountBits-1:0] count
);

	// Access phase must follow a setup cycle
	setupBeforeAccess: assert property (@(posedge clk) disable iff (rst)
		$rose(penable) |-> psel && $past(psel) && !$past(penable))
		else $error("penable rose without a setup cycle");

	// Reservations keep a slot for each result in flight so the count stays within depth
	countInRange: assert property (@(posedge clk) disable iff (rst)
		resultValid |-> count < acclPkg::FifoDepth)
		else $error("result pushed into a full queue");

	// Error only answers a completing read of an empty queue and carries zero data
	errorOnlyOnCompletion: assert property (@(posedge clk) disable iff (rst)
		pslverr |-> psel && penable && pready && !pwrite &&
			count == '0 && prdata == '0)
		else $error("pslverr outside a completing read of an empty queue");

endmodule

bind convAcclTop tbAccl_asserts uAsserts (
	.clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
	.pready(pready), .pslverr(pslverr), .prdata(prdata),
	.resultValid(resultValid), .count(count)
);
